//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= reaction_game_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
logic/game_pkg.sv
logic/key_decoder.sv
logic/game_control.sv
logic/round_timer.sv
logic/target_lfsr.sv
logic/score_display.sv
logic/reaction_game_top.sv
verification/reaction_game_asserts.sv
verification/reaction_game_tb.sv

//--- logic/game_control.sv
`timescale 1ns/1ps

module game_control import game_pkg::*; (
  input  logic   clk,
  input  logic   out_rst,
  input  logic   start_pulse,
  input  logic   goal_met,
  input  logic   time_up,
  input  logic   hold_done,
  output phase_t phase,
  output logic   result
);

  phase_t phase_nxt;
  logic   round_end;

  assign round_end = goal_met || time_up;

  always_comb begin
    phase_nxt = phase;
    case (phase)
      PH_IDLE: begin
        if (start_pulse)
          phase_nxt = PH_SET;
      end
      PH_SET: begin
        if (start_pulse)
          phase_nxt = PH_GAME;
      end
      PH_GAME: begin
        if (round_end)
          phase_nxt = PH_FINAL;
      end
      PH_FINAL: begin
        if (hold_done)
          phase_nxt = PH_IDLE;
      end
      default: phase_nxt = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      phase  <= PH_IDLE;
      result <= 1'b0;
    end else begin
      phase <= phase_nxt;
      // goal wins over timeout when both land together
      if (phase == PH_GAME && round_end)
        result <= goal_met;
    end
  end

endmodule

//--- logic/game_pkg.sv
package game_pkg;

  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_SET   = 2'd1,
    PH_GAME  = 2'd2,
    PH_FINAL = 2'd3
  } phase_t;

  typedef struct packed {
    logic       valid;
    logic       is_digit;
    logic       is_space;
    logic [3:0] digit;
  } key_evt_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic       adr;
    logic [8:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [8:0] dat;
  } wb_rsp_t;

  localparam int TICK_CYCLES = 8;        // cycles per game second
  localparam int FINAL_TICKS = 4;
  localparam int TICK_W = $clog2(TICK_CYCLES);
  localparam int HOLD_W = $clog2(FINAL_TICKS + 1);

  localparam logic [8:0]  LFSR_SEED    = 9'h160;
  localparam logic [7:0]  DEFAULT_TIME = 8'h30;  // bcd
  localparam logic [7:0]  DEFAULT_GOAL = 8'h10;  // bcd
  localparam logic [8:0]  SPACE_CODE   = 9'h029;
  localparam logic        ADR_KEY      = 1'b0;
  localparam logic        ADR_START    = 1'b1;
  localparam logic [15:0] NUMS_IDLE    = 16'hFFFF;
  localparam logic [15:0] NUMS_WIN     = 16'hFABC;
  localparam logic [15:0] NUMS_LOSE    = 16'hD05E;

endpackage

//--- logic/key_decoder.sv
`timescale 1ns/1ps

module key_decoder import game_pkg::*; (
  input  logic     clk,
  input  logic     out_rst,
  input  wb_req_t  bus_req,
  input  phase_t   phase,
  input  logic     result,
  output wb_rsp_t  bus_rsp,
  output key_evt_t key_evt,
  output logic     start_pulse
);

  logic     ack_q;
  logic     evt_valid_q;
  key_evt_t evt_q;
  logic [8:0] rdat_q;
  logic     accept;

  // main row and keypad digit codes
  function automatic key_evt_t decode(input logic [8:0] code);
    key_evt_t e;
    e = '{valid: 1'b1, is_digit: 1'b1, is_space: 1'b0, digit: 4'd0};
    case (code)
      9'h045, 9'h070: e.digit = 4'd0;
      9'h016, 9'h069: e.digit = 4'd1;
      9'h01E, 9'h072: e.digit = 4'd2;
      9'h026, 9'h07A: e.digit = 4'd3;
      9'h025, 9'h06B: e.digit = 4'd4;
      9'h02E, 9'h073: e.digit = 4'd5;
      9'h036, 9'h074: e.digit = 4'd6;
      9'h03D, 9'h06C: e.digit = 4'd7;
      9'h03E, 9'h075: e.digit = 4'd8;
      9'h046, 9'h07D: e.digit = 4'd9;
      default: begin
        e.is_digit = 1'b0;
        e.is_space = (code == SPACE_CODE);
      end
    endcase
    return e;
  endfunction

  assign accept = bus_req.cyc && bus_req.stb && !ack_q; // no back-to-back acks

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      ack_q       <= 1'b0;
      evt_valid_q <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      ack_q       <= accept;
      evt_valid_q <= accept && bus_req.we && (bus_req.adr == ADR_KEY);
      start_pulse <= accept && bus_req.we && (bus_req.adr == ADR_START);
    end
  end

  always_ff @(posedge clk) begin
    if (accept && bus_req.we && bus_req.adr == ADR_KEY)
      evt_q <= decode(bus_req.dat);
    if (accept && !bus_req.we)
      rdat_q <= {6'd0, result, phase}; // status word
  end

  assign key_evt = '{valid: evt_valid_q, is_digit: evt_q.is_digit,
                     is_space: evt_q.is_space, digit: evt_q.digit};
  assign bus_rsp = '{ack: ack_q, dat: rdat_q};

endmodule

//--- logic/reaction_game_top.sv
`timescale 1ns/1ps

module reaction_game_top import game_pkg::*; (
  input  logic        clk,
  input  logic        out_rst,
  input  wb_req_t     bus_req,
  output wb_rsp_t     bus_rsp,
  output logic [15:0] led,
  output logic [15:0] nums
);

  phase_t     phase;
  key_evt_t   key_evt;
  logic       start_pulse;
  logic       result;
  logic       goal_met;
  logic       time_up;
  logic       hold_done;
  logic       tick;
  logic       edit_goal;
  logic [7:0] time_limit;
  logic [7:0] remaining;

  key_decoder u_key_decoder (
    .clk(clk), .out_rst(out_rst), .bus_req(bus_req), .phase(phase), .result(result),
    .bus_rsp(bus_rsp), .key_evt(key_evt), .start_pulse(start_pulse)
  );

  game_control u_game_control (
    .clk(clk), .out_rst(out_rst), .start_pulse(start_pulse), .goal_met(goal_met),
    .time_up(time_up), .hold_done(hold_done), .phase(phase), .result(result)
  );

  round_timer u_round_timer (
    .clk(clk), .out_rst(out_rst), .phase(phase), .time_limit(time_limit), .tick(tick),
    .remaining(remaining), .time_up(time_up), .hold_done(hold_done)
  );

  target_lfsr u_target_lfsr (
    .clk(clk), .out_rst(out_rst), .phase(phase), .tick(tick), .edit_goal(edit_goal),
    .led(led)
  );

  score_display u_score_display (
    .clk(clk), .out_rst(out_rst), .phase(phase), .result(result), .key_evt(key_evt),
    .led(led), .remaining(remaining), .edit_goal(edit_goal), .time_limit(time_limit),
    .goal_met(goal_met), .nums(nums)
  );

endmodule

//--- logic/round_timer.sv
`timescale 1ns/1ps

module round_timer import game_pkg::*; (
  input  logic       clk,
  input  logic       out_rst,
  input  phase_t     phase,
  input  logic [7:0] time_limit,
  output logic       tick,
  output logic [7:0] remaining,
  output logic       time_up,
  output logic       hold_done
);

  phase_t              phase_q;
  logic [TICK_W-1:0]   cyc_cnt;
  logic [HOLD_W-1:0]   hold_cnt;

  // counter restarts on every phase change
  assign tick = (phase == phase_q) && (cyc_cnt == TICK_W'(TICK_CYCLES - 1));

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      phase_q   <= PH_IDLE;
      cyc_cnt   <= '0;
      hold_cnt  <= '0;
      remaining <= 8'd0;
    end else begin
      phase_q <= phase;
      if (phase != phase_q || tick)
        cyc_cnt <= '0;
      else
        cyc_cnt <= cyc_cnt + 1'b1;

      if (phase == PH_SET)
        remaining <= time_limit;         // ready when game starts
      else if (phase == PH_GAME && tick && remaining != 8'd0)
        remaining <= remaining - 8'd1;

      if (phase != PH_FINAL)
        hold_cnt <= '0;
      else if (tick)
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  assign time_up   = (phase == PH_GAME) && (remaining == 8'd0);
  assign hold_done = (phase == PH_FINAL) && tick && (hold_cnt == HOLD_W'(FINAL_TICKS - 1));

endmodule

//--- logic/score_display.sv
`timescale 1ns/1ps

module score_display import game_pkg::*; (
  input  logic        clk,
  input  logic        out_rst,
  input  phase_t      phase,
  input  logic        result,
  input  key_evt_t    key_evt,
  input  logic [15:0] led,
  input  logic [7:0]  remaining,
  output logic        edit_goal,
  output logic [7:0]  time_limit,
  output logic        goal_met,
  output logic [15:0] nums
);

  logic [7:0] time_bcd;
  logic [7:0] goal_bcd;
  logic [7:0] hit_bcd;
  logic [3:0] hit_idx;
  logic       hit;

  function automatic logic [7:0] to_bcd(input logic [7:0] b);
    logic [7:0] tens;
    logic [7:0] ones;
    tens = b / 8'd10;
    ones = b % 8'd10;
    return {tens[3:0], ones[3:0]};
  endfunction

  function automatic logic [7:0] bcd_inc(input logic [7:0] v);
    if (v == 8'h99)
      return v;                          // saturate at 99
    if (v[3:0] == 4'd9)
      return {v[7:4] + 4'd1, 4'd0};
    return {v[7:4], v[3:0] + 4'd1};
  endfunction

  assign hit_idx = 4'(5'd16 - {1'b0, key_evt.digit});
  assign hit     = key_evt.valid && key_evt.is_digit && (key_evt.digit != 4'd0) &&
                   led[hit_idx];

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      time_bcd  <= DEFAULT_TIME;
      goal_bcd  <= DEFAULT_GOAL;
      hit_bcd   <= 8'h00;
      edit_goal <= 1'b0;
    end else begin
      case (phase)
        PH_IDLE: begin
          time_bcd  <= DEFAULT_TIME;
          goal_bcd  <= DEFAULT_GOAL;
          hit_bcd   <= 8'h00;
          edit_goal <= 1'b0;
        end
        PH_SET: begin
          if (key_evt.valid && key_evt.is_space)
            edit_goal <= ~edit_goal;
          else if (key_evt.valid && key_evt.is_digit && edit_goal)
            goal_bcd <= {goal_bcd[3:0], key_evt.digit};
          else if (key_evt.valid && key_evt.is_digit)
            time_bcd <= {time_bcd[3:0], key_evt.digit};
        end
        PH_GAME: begin
          if (hit)
            hit_bcd <= bcd_inc(hit_bcd);
        end
        default: ;
      endcase
    end
  end

  assign time_limit = 8'(time_bcd[7:4]) * 8'd10 + 8'(time_bcd[3:0]);
  assign goal_met   = (phase == PH_GAME) && (hit_bcd == goal_bcd);

  always_comb begin
    case (phase)
      PH_SET:   nums = {time_bcd, goal_bcd};
      PH_GAME:  nums = {to_bcd(remaining), hit_bcd};
      PH_FINAL: nums = result ? NUMS_WIN : NUMS_LOSE;
      default:  nums = NUMS_IDLE;
    endcase
  end

endmodule

//--- logic/target_lfsr.sv
`timescale 1ns/1ps

module target_lfsr import game_pkg::*; (
  input  logic        clk,
  input  logic        out_rst,
  input  phase_t      phase,
  input  logic        tick,
  input  logic        edit_goal,
  output logic [15:0] led
);

  logic [8:0] lfsr;
  logic [8:0] lfsr_nxt;
  logic       flash;

  // right shift, bit 0 fed back into 8, 6, 5 and 3
  assign lfsr_nxt = {lfsr[0], lfsr[8], lfsr[7] ^ lfsr[0], lfsr[6] ^ lfsr[0],
                     lfsr[5], lfsr[4] ^ lfsr[0], lfsr[3], lfsr[2], lfsr[1]};

  always_ff @(posedge clk or posedge out_rst) begin
    if (out_rst) begin
      lfsr  <= LFSR_SEED;
      flash <= 1'b0;
      led   <= 16'h0000;
    end else begin
      if (phase != PH_GAME)
        lfsr <= LFSR_SEED;
      else if (tick)
        lfsr <= lfsr_nxt;

      if (phase != PH_FINAL)
        flash <= 1'b0;                   // final screen starts dark
      else if (tick)
        flash <= ~flash;

      case (phase)
        PH_IDLE:  led <= 16'h8001;
        PH_SET:   led <= edit_goal ? 16'h80FF : 16'hFF01;
        PH_GAME:  led <= {lfsr, 7'b0000011};
        PH_FINAL: led <= {16{flash}};
        default:  led <= 16'h0000;
      endcase
    end
  end

endmodule

//--- verification/game_input.txt
# columns in hex: test op operand expected
# op 1 key 2 start 3 status 4 wait cycles 5 nums 6 led 7 hit 8 miss 9 nums model a led model
1 6 0 0000
1 4 1 0
1 6 0 8001
1 5 0 ffff
1 3 0 0
6 1 16 0
6 5 0 ffff
6 6 0 8001
2 2 0 0
2 4 1 0
2 6 0 ff01
2 5 0 3010
2 1 16 0
2 5 0 0110
2 1 72 0
2 5 0 1210
2 1 1e 0
2 5 0 2210
2 1 1c 0
2 5 0 2210
2 1 29 0
2 4 1 0
2 6 0 80ff
2 1 45 0
2 1 1e 0
2 5 0 2202
3 2 0 0
3 9 0 0
3 8 0 0
3 9 0 0
3 1 45 0
3 9 0 0
3 7 0 0
3 9 0 0
3 4 14 0
3 a 0 0
4 7 0 0
4 9 0 0
4 4 8 0
4 5 0 fabc
4 3 0 7
4 4 28 0
4 3 0 4
4 6 0 8001
4 5 0 ffff
5 2 0 0
5 1 45 0
5 1 1e 0
5 5 0 0210
5 2 0 0
5 4 8 0
5 9 0 0
5 4 8 0
5 9 0 0
5 4 8 0
5 5 0 d05e
5 3 0 3
5 6 0 0000
6 1 16 0
6 5 0 d05e
6 6 0 ffff
5 4 8 0
5 6 0 0000
5 4 8 0
5 6 0 ffff
5 4 18 0
5 3 0 0
5 6 0 8001

//--- verification/reaction_game_asserts.sv
`timescale 1ns/1ps

module reaction_game_asserts import game_pkg::*; (
  input logic     clk,
  input logic     out_rst,
  input wb_req_t  bus_req,
  input wb_rsp_t  bus_rsp,
  input phase_t   phase,
  input key_evt_t key_evt,
  input logic     start_pulse
);

  ack_after_req: assert property (@(posedge clk) disable iff (out_rst)
    $rose(bus_rsp.ack) |-> $past(bus_req.cyc && bus_req.stb))
    else $error("ack raised without a request in the previous cycle");

  single_ack: assert property (@(posedge clk) disable iff (out_rst)
    bus_rsp.ack |=> !bus_rsp.ack)
    else $error("ack high on two cycles in a row");

  // idle, set, game, final and back to idle
  phase_order: assert property (@(posedge clk) disable iff (out_rst)
    (phase != $past(phase)) |-> (phase == phase_t'($past(phase) + 2'd1)))
    else $error("phase skipped a step");

  start_or_key: assert property (@(posedge clk) disable iff (out_rst)
    !(start_pulse && key_evt.valid))
    else $error("start pulse and key event in the same cycle");

endmodule

bind key_decoder reaction_game_asserts u_asserts (
  .clk(clk), .out_rst(out_rst), .bus_req(bus_req), .bus_rsp(bus_rsp),
  .phase(phase), .key_evt(key_evt), .start_pulse(start_pulse)
);

//--- verification/reaction_game_tb.sv
`timescale 1ns/1ps

module reaction_game_tb import game_pkg::*; ();

  logic        clk;
  logic        out_rst;
  wb_req_t     bus_req;
  wb_rsp_t     bus_rsp;
  logic [15:0] led;
  logic [15:0] nums;

  localparam logic [8:0] MAIN_CODES [10] = '{9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
                                             9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046};
  localparam logic [8:0] PAD_CODES [10]  = '{9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
                                             9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D};

  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 32'hFFFF_FFFF;
  logic [31:0] rnd_state = 32'h381d_c944;
  string       cur_test = "startup";

  // reference model state
  phase_t      m_phase;
  logic [7:0]  m_time;
  logic [7:0]  m_goal;
  logic        m_edit;
  int          m_hits;
  int          m_limit;
  int unsigned game_c;                  // first cycle with the game counter running

  reaction_game_top u_dut (
    .clk(clk), .out_rst(out_rst), .bus_req(bus_req), .bus_rsp(bus_rsp),
    .led(led), .nums(nums)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
      abort_run("timeout: the run took more cycles than the test steps allow");
  end

  task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
    if (exp !== act)
      abort_run($sformatf("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rnd_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rnd_state = x;
    return x;
  endfunction

  function automatic string test_name(input int code);
    case (code)
      1: return "reset_idle";
      2: return "set_entry";
      3: return "game_hits";
      4: return "win_round";
      5: return "lose_round";
      6: return "ignored_keys";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic [7:0] to_bcd(input int v);
    return {4'(v / 10), 4'(v % 10)};
  endfunction

  function automatic int code_digit(input logic [8:0] code);
    for (int d = 0; d < 10; d++)
      if (code == MAIN_CODES[d] || code == PAD_CODES[d])
        return d;
    return -1;
  endfunction

  function automatic logic [15:0] led_model(input int unsigned n);
    logic [8:0] l;
    int steps;
    l = LFSR_SEED;
    steps = (n > game_c) ? int'((n - game_c - 1) / TICK_CYCLES) : 0;
    for (int i = 0; i < steps; i++) begin
      if (l[0])
        l = (l >> 1) ^ 9'h168;         // taps at 8, 6, 5, 3
      else
        l = l >> 1;
    end
    return {l, 7'b0000011};
  endfunction

  function automatic int rem_model(input int unsigned n);
    int ticks;
    ticks = (n > game_c) ? int'((n - game_c) / TICK_CYCLES) : 0;
    return (ticks >= m_limit) ? 0 : m_limit - ticks;
  endfunction

  // one classic single transfer, called on a falling edge
  task automatic bus_xfer(input logic we, input logic adr, input logic [8:0] dat,
                          output logic [8:0] rdat);
    int wait_cnt;
    wait_cnt = 0;
    bus_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (!bus_rsp.ack);
    check("ack latency", 16'd1, 16'(wait_cnt));
    rdat = bus_rsp.dat;
    bus_req = '0;
    @(negedge clk);
  endtask

  task automatic write_key(input logic [8:0] code);
    logic [8:0]  rd;
    logic [15:0] ml;
    int d;
    d = code_digit(code);
    ml = led_model(cycle_cnt + 1);      // led seen by the key event
    if (m_phase == PH_SET && code == SPACE_CODE)
      m_edit = ~m_edit;
    else if (m_phase == PH_SET && d >= 0 && m_edit)
      m_goal = {m_goal[3:0], 4'(d)};
    else if (m_phase == PH_SET && d >= 0)
      m_time = {m_time[3:0], 4'(d)};
    else if (m_phase == PH_GAME && d > 0 && ml[16 - d])
      m_hits++;
    bus_xfer(1'b1, ADR_KEY, code, rd);
  endtask

  task automatic write_start();
    logic [8:0] rd;
    if (m_phase == PH_IDLE) begin
      m_phase = PH_SET;
      m_time  = DEFAULT_TIME;
      m_goal  = DEFAULT_GOAL;
      m_edit  = 1'b0;
    end else if (m_phase == PH_SET) begin
      check("settings", {m_time, m_goal}, nums);  // time above goal
      m_phase = PH_GAME;
      m_hits  = 0;
      m_limit = int'(m_time[7:4]) * 10 + int'(m_time[3:0]);
    end
    bus_xfer(1'b1, ADR_START, 9'd0, rd);
    if (m_phase == PH_GAME)
      game_c = cycle_cnt + 1;
  endtask

  task automatic read_status(input logic [15:0] exp);
    logic [8:0] rd;
    bus_xfer(1'b0, ADR_KEY, 9'd0, rd);
    check("status", exp, 16'(rd));
    m_phase = phase_t'(exp[1:0]);
  endtask

  // lit = 1 aims at a lit target, lit = 0 at a dark one
  task automatic press_target(input logic lit);
    logic [15:0] ml;
    logic [31:0] r;
    int cand[$];
    ml = led_model(cycle_cnt + 1);
    for (int d = 1; d < 10; d++)
      if (ml[16 - d] == lit)
        cand.push_back(d);
    if (cand.size() == 0 && lit)
      abort_run("no lit LED found for a hit step");
    if (cand.size() == 0) begin
      write_key(MAIN_CODES[0]);         // key 0 never scores
    end else begin
      r = next_rand();
      if (r[16])
        write_key(PAD_CODES[cand[r % cand.size()]]);
      else
        write_key(MAIN_CODES[cand[r % cand.size()]]);
    end
  endtask

  initial begin
    int fd;
    int nm;
    int op;
    int opnd;
    int ex;
    int wait_sum;
    string line;
    int q_nm[$];
    int q_op[$];
    int q_opnd[$];
    int q_ex[$];
    clk     = 1'b0;
    out_rst = 1'b1;
    bus_req = '0;
    m_phase = PH_IDLE;
    m_time  = DEFAULT_TIME;
    m_goal  = DEFAULT_GOAL;
    m_edit  = 1'b0;
    m_hits  = 0;
    m_limit = 0;
    game_c  = 0;
    wait_sum = 0;
    fd = $fopen("verification/game_input.txt", "r");
    if (fd == 0)
      abort_run("cannot open verification/game_input.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line.getc(0) != "#" &&
          $sscanf(line, "%h %h %h %h", nm, op, opnd, ex) == 4) begin
        q_nm.push_back(nm);
        q_op.push_back(op);
        q_opnd.push_back(opnd);
        q_ex.push_back(ex);
        if (op == 4)
          wait_sum += opnd;
      end
    end
    $fclose(fd);
    // bus steps take 2 cycles, plus the longest round and hold
    cycle_limit = 2 * (10 + wait_sum + 4 * q_op.size() + (99 + FINAL_TICKS + 2) * TICK_CYCLES);

    repeat (10) @(negedge clk);
    out_rst = 1'b0;

    foreach (q_op[i]) begin
      cur_test = test_name(q_nm[i]);
      case (q_op[i])
        1: write_key(9'(q_opnd[i]));
        2: write_start();
        3: read_status(16'(q_ex[i]));
        4: repeat (q_opnd[i]) @(negedge clk);
        5: check("nums", 16'(q_ex[i]), nums);
        6: check("led", 16'(q_ex[i]), led);
        7: press_target(1'b1);
        8: press_target(1'b0);
        9: check("nums model", {to_bcd(rem_model(cycle_cnt)), to_bcd(m_hits)}, nums);
        10: check("led model", led_model(cycle_cnt), led);
        default: abort_run($sformatf("unknown operation %0d in the stimulus file", q_op[i]));
      endcase
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
